//--- fetch_frontend.f
+incdir+tests
hdl/frontend_pkg.sv
hdl/trap_target.sv
hdl/fetch_pc_gen.sv
hdl/fetch_pipe.sv
hdl/fetch_buffer.sv
hdl/fetch_frontend.sv
tests/fetch_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with verilator
# exit status follows the pass line in the simulation output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_frontend_tb -f fetch_frontend.f \
  --Mdir obj_dir -o fetch_frontend_sim &&
./obj_dir/fetch_frontend_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "fetch_frontend: run passed" ||
{ echo "fetch_frontend: run failed"; exit 1; }

//--- tests/fetch_frontend_checks.svh
// compare tasks for fetch addresses and fetch blocks
// reference model of block addresses, block data and redirect targets

`ifndef FETCH_FRONTEND_CHECKS_SVH
`define FETCH_FRONTEND_CHECKS_SVH

// ============================================================================
// failure reporting
// ============================================================================

task automatic stop_with_failure(input string why);
  $display("%s", why);
  $display("SIMULATION FAILED");
  $fatal(1);
endtask

// address and block compares
task automatic check_vaddr(input vaddr_t got, input vaddr_t exp, input string what);
  if (got !== exp) begin
    stop_with_failure($sformatf("Mismatch at time %0t: %s got %08h expected %08h",
                                $time, what, got, exp));
  end
endtask

task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp,
                           input string what);
  if (got !== exp) begin
    stop_with_failure($sformatf(
      "Mismatch at time %0t: %s got pc %08h data %016h expected pc %08h data %016h",
      $time, what, got.pc, got.data, exp.pc, exp.data));
  end
endtask

// ============================================================================
// reference model
// ============================================================================

function automatic vaddr_t align_block(input vaddr_t a);
  return a & ~vaddr_t'(FETCH_BYTES - 1);
endfunction

// sequential fetch steps from the aligned block
function automatic vaddr_t next_block_pc(input vaddr_t pc);
  return align_block(pc) + vaddr_t'(FETCH_BYTES);
endfunction

// cache contents hold the aligned address in both halves
function automatic fetch_data_t block_data(input vaddr_t pc);
  return {align_block(pc), align_block(pc)};
endfunction

function automatic vaddr_t expected_trap_target(input commit_t c, input csr_vec_t csr,
                                                input br_upd_t br);
  vaddr_t t;
  int     code;
  code = int'(c.except_type);
  if (!c.flush) begin
    // no commit leaves the mispredict target
    t = br.target;
  end else if (c.is_int) begin
    t = (csr.mtvec & 32'hffff_fffe) + vaddr_t'(4 * int'(c.int_cause));
  end else if (c.except_type == MRET) begin
    t = csr.mepc;
  end else if (c.except_type == SRET) begin
    t = csr.sepc;
  end else if (c.except_type == SILENT_FLUSH) begin
    t = c.epc + 32'd4;
  end else if (c.except_type == ANOTHER_FLUSH) begin
    t = c.epc;
  end else begin
    // exception code is its own medeleg bit
    t = csr.medeleg[code] ? csr.stvec : csr.mtvec;
  end
  return t;
endfunction

`endif

//--- tests/fetch_frontend_tb.sv
// testbench for the fetch front end
// clock, reset, icache model, fetch sink, watchdog and directed tests

`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb
  import frontend_pkg::*;
();

  localparam int RESET_CYCLES    = 10;
  // average cycles allowed per block under heavy stalls
  localparam int BLOCK_BUDGET    = 16;
  localparam int RUN_BLOCKS      = 32 + 64 + 64 + 3 * 8 + 24 * 4 + 7 * 4;
  localparam int WATCHDOG_CYCLES = RUN_BLOCKS * BLOCK_BUDGET + RESET_CYCLES + 400;

  logic         clk;
  logic         reset_n;
  commit_t      commit;
  csr_vec_t     csr;
  br_upd_t      br_upd;
  logic         ic_ready;
  ic_req_t      ic_req;
  ic_resp_t     ic_resp;
  logic         fetch_ready;
  logic         fetch_valid;
  fetch_entry_t fetch;

  // traffic shaping in percent per cycle
  integer       seed;
  int           miss_pct;
  int           ic_stall_pct;
  int           sink_stall_pct;
  // accepted requests where index 2 answers this cycle
  logic         acc_valid [3];
  vaddr_t       acc_vaddr [3];
  csr_vec_t     csr_cfg;
  // redirect handoff between tests and the model
  logic         redirect_pending;
  logic         redirect_now;
  logic         check_target_req;
  commit_t      pend_commit;
  br_upd_t      pend_br;
  vaddr_t       pend_exp;
  // scoreboard
  vaddr_t       exp_pc;
  fetch_entry_t exp_entry;
  int           blocks_seen;

  `include "fetch_frontend_checks.svh"

  fetch_frontend dut_i (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_commit      (commit),
    .i_csr         (csr),
    .i_br_upd      (br_upd),
    .i_ic_ready    (ic_ready),
    .o_ic_req      (ic_req),
    .i_ic_resp     (ic_resp),
    .i_fetch_ready (fetch_ready),
    .o_fetch_valid (fetch_valid),
    .o_fetch       (fetch)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int draw_pct();
    return int'($unsigned($random(seed)) % 32'd100);
  endfunction

  // ==========================================================================
  // icache model, sink and scoreboard
  // ==========================================================================

  initial begin
    seed             = 58555;
    commit           = '0;
    csr              = '0;
    br_upd           = '0;
    ic_ready         = 1'b0;
    ic_resp          = '0;
    fetch_ready      = 1'b0;
    acc_valid        = '{1'b0, 1'b0, 1'b0};
    acc_vaddr        = '{32'h0, 32'h0, 32'h0};
    redirect_pending = 1'b0;
    redirect_now     = 1'b0;
    check_target_req = 1'b0;
    exp_pc           = PC_INIT_VAL;
    blocks_seen      = 0;
    forever begin
      @(negedge clk);
      acc_valid[2] = acc_valid[1];
      acc_vaddr[2] = acc_vaddr[1];
      acc_valid[1] = acc_valid[0];
      acc_vaddr[1] = acc_vaddr[0];
      // answer two cycles after acceptance in line with f2
      if (acc_valid[2]) begin
        ic_resp.valid = 1'b1;
        ic_resp.miss  = (draw_pct() < miss_pct);
        ic_resp.data  = ic_resp.miss ? '0 : block_data(acc_vaddr[2]);
      end else begin
        ic_resp = '0;
      end
      ic_ready    = (draw_pct() >= ic_stall_pct);
      fetch_ready = (draw_pct() >= sink_stall_pct);
      csr         = csr_cfg;
      // a redirect lasts one cycle
      redirect_now = redirect_pending;
      if (redirect_pending) begin
        commit           = pend_commit;
        br_upd           = pend_br;
        redirect_pending = 1'b0;
      end else begin
        commit = '0;
        br_upd = '0;
      end
      #1;
      acc_valid[0] = ic_req.valid & ic_ready;
      acc_vaddr[0] = ic_req.vaddr;
      // target request one cycle after the flush
      if (check_target_req) begin
        check_target_req = 1'b0;
        if (!ic_req.valid) begin
          stop_with_failure("no icache request in the cycle after a redirect");
        end else begin
          check_vaddr(ic_req.vaddr, pend_exp, "redirect request");
        end
      end
      if (fetch_valid && fetch_ready) begin
        exp_entry.pc   = exp_pc;
        exp_entry.data = block_data(exp_pc);
        check_entry(fetch, exp_entry, "fetch block");
        exp_pc = next_block_pc(exp_pc);
        blocks_seen++;
      end
      // blocks after the flush cycle belong to the new stream
      if (redirect_now) begin
        exp_pc           = pend_exp;
        check_target_req = 1'b1;
      end
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic set_traffic(input int miss, input int ic_stall, input int sink_stall);
    miss_pct       = miss;
    ic_stall_pct   = ic_stall;
    sink_stall_pct = sink_stall;
  endtask

  task automatic wait_blocks(input int n);
    int target;
    int cycles;
    target = blocks_seen + n;
    cycles = 0;
    while (blocks_seen < target && cycles < n * BLOCK_BUDGET) begin
      @(posedge clk);
      cycles++;
    end
    if (blocks_seen < target) begin
      stop_with_failure($sformatf("only %0d of %0d fetch blocks arrived in time",
                                  blocks_seen - (target - n), n));
    end
  endtask

  // hands the redirect to the model for the next falling edge
  task automatic issue_redirect(input commit_t c, input br_upd_t b);
    @(posedge clk);
    pend_commit      = c;
    pend_br          = b;
    pend_exp         = expected_trap_target(c, csr_cfg, b);
    redirect_pending = 1'b1;
    while (redirect_pending) begin
      @(posedge clk);
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================

  task automatic test_sequential();
    #2;
    if (ic_req.valid || fetch_valid) begin
      stop_with_failure("request or fetch output valid right after reset");
    end else begin
      // requests start in the first cycle out of reset
      @(posedge clk);
      #2;
      if (!ic_req.valid) begin
        stop_with_failure("no icache request in the first cycle after reset");
      end else begin
        check_vaddr(ic_req.vaddr, PC_INIT_VAL, "first request after reset");
        set_traffic(0, 0, 0);
        wait_blocks(32);
      end
    end
  endtask

  task automatic test_cache_stalls();
    set_traffic(25, 30, 0);
    wait_blocks(64);
  endtask

  // sink stalls fill the buffer and force refetches
  task automatic test_backpressure();
    set_traffic(0, 0, 70);
    wait_blocks(64);
  endtask

  task automatic test_mispredict();
    vaddr_t  targets [3];
    br_upd_t b;
    int      i;
    targets = '{32'h8000_1234, 32'h0000_4000, 32'h8000_0ffc};
    set_traffic(10, 10, 20);
    for (i = 0; i < 3; i++) begin
      b = '{valid: 1'b1, mispredict: 1'b1, target: targets[i]};
      issue_redirect('0, b);
      wait_blocks(8);
    end
  endtask

  // every commit kind with its medeleg bit set and clear
  task automatic test_commit_kinds();
    except_t kinds [12];
    commit_t c;
    int      k;
    int      d;
    int      code;
    kinds = '{INST_ADDR_MISALIGN, INST_ACC_FAULT, ILLEGAL_INST, BREAKPOINT,
              ECALL_U, ECALL_S, ECALL_M, INST_PAGE_FAULT,
              SILENT_FLUSH, ANOTHER_FLUSH, MRET, SRET};
    for (k = 0; k < 12; k++) begin
      for (d = 0; d < 2; d++) begin
        code = int'(kinds[k]);
        if (code < 16) begin
          // other bits opposite to catch a wrong index
          csr_cfg.medeleg = (d == 1) ? (16'h1 << code) : ~(16'h1 << code);
        end else begin
          csr_cfg.medeleg = (d == 1) ? 16'hffff : 16'h0000;
        end
        c = '{flush: 1'b1, is_int: 1'b0, except_type: kinds[k],
              int_cause: SUPER_SOFT_INT, epc: 32'h8000_5004 + vaddr_t'(k * 32)};
        issue_redirect(c, '0);
        wait_blocks(4);
      end
    end
  endtask

  task automatic test_interrupts();
    int_cause_t causes [6];
    commit_t    c;
    br_upd_t    b;
    int         i;
    causes = '{SUPER_SOFT_INT, MACHINE_SOFT_INT, SUPER_TIMER_INT,
               MACHINE_TIMER_INT, SUPER_EXTERNAL_INT, MACHINE_EXTERNAL_INT};
    for (i = 0; i < 6; i++) begin
      c = '{flush: 1'b1, is_int: 1'b1, except_type: ECALL_M,
            int_cause: causes[i], epc: 32'h8000_6000};
      issue_redirect(c, '0);
      wait_blocks(4);
    end
    // commit and mispredict together where the commit wins
    c = '{flush: 1'b1, is_int: 1'b0, except_type: ILLEGAL_INST,
          int_cause: SUPER_SOFT_INT, epc: 32'h8000_7000};
    b = '{valid: 1'b1, mispredict: 1'b1, target: 32'h0000_9000};
    issue_redirect(c, b);
    wait_blocks(4);
  endtask

  // ==========================================================================
  // sequence and watchdog
  // ==========================================================================

  initial begin
    set_traffic(0, 0, 0);
    // mode bit set in mtvec so interrupts must drop it
    csr_cfg = '{mtvec: 32'h0000_1001, stvec: 32'h0000_2000, mepc: 32'h8000_3010,
                sepc: 32'h8000_4020, medeleg: 16'h0000};
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b1;
    test_sequential();
    test_cache_stalls();
    test_backpressure();
    test_mispredict();
    test_commit_kinds();
    test_interrupts();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
// fetch front end top level
// redirect target, f0 pc, f1/f2 pipe and fetch buffer

`timescale 1ns/1ps
`default_nettype none

module fetch_frontend
  import frontend_pkg::*;
(
  input  wire               i_clk,
  input  wire               i_reset_n,
  // redirect sources
  input  wire commit_t      i_commit,
  input  wire csr_vec_t     i_csr,
  input  wire br_upd_t      i_br_upd,
  // icache
  input  wire               i_ic_ready,
  output ic_req_t           o_ic_req,
  input  wire ic_resp_t     i_ic_resp,
  // decode side
  input  wire               i_fetch_ready,
  output logic              o_fetch_valid,
  output fetch_entry_t      o_fetch
);

  logic         w_flush_valid;
  vaddr_t       w_flush_target;
  logic         w_refetch_valid;
  vaddr_t       w_refetch_vaddr;
  logic         w_f0_issue;
  logic         w_push;
  fetch_entry_t w_push_entry;
  logic         w_buf_full;

  // ==========================================================================
  // redirect
  // ==========================================================================

  trap_target trap_target_i (
    .i_commit       (i_commit),
    .i_csr          (i_csr),
    .i_br_upd       (i_br_upd),
    .o_flush_valid  (w_flush_valid),
    .o_flush_target (w_flush_target)
  );

  // ==========================================================================
  // fetch pipeline
  // ==========================================================================

  fetch_pc_gen fetch_pc_gen_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush_valid   (w_flush_valid),
    .i_flush_target  (w_flush_target),
    .i_refetch_valid (w_refetch_valid),
    .i_refetch_vaddr (w_refetch_vaddr),
    .i_ic_ready      (i_ic_ready),
    .o_ic_req        (o_ic_req),
    .o_f0_issue      (w_f0_issue)
  );

  // f0 address comes straight off the request
  fetch_pipe fetch_pipe_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_f0_issue      (w_f0_issue),
    .i_f0_vaddr      (o_ic_req.vaddr),
    .i_flush_valid   (w_flush_valid),
    .i_ic_resp       (i_ic_resp),
    .i_buf_full      (w_buf_full),
    .o_refetch_valid (w_refetch_valid),
    .o_refetch_vaddr (w_refetch_vaddr),
    .o_push          (w_push),
    .o_push_entry    (w_push_entry)
  );

  fetch_buffer fetch_buffer_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_flush_valid  (w_flush_valid),
    .i_push         (w_push),
    .i_push_entry   (w_push_entry),
    .o_full         (w_buf_full),
    .i_fetch_ready  (i_fetch_ready),
    .o_fetch_valid  (o_fetch_valid),
    .o_fetch        (o_fetch)
  );

endmodule

`default_nettype wire

//--- hdl/fetch_buffer.sv
// fetch block FIFO with flush
// valid/ready output toward decode

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer
  import frontend_pkg::*;
(
  input  wire                i_clk,
  input  wire                i_reset_n,
  input  wire                i_flush_valid,
  // write side from f2
  input  wire                i_push,
  input  wire fetch_entry_t  i_push_entry,
  output logic               o_full,
  // read side
  input  wire                i_fetch_ready,
  output logic               o_fetch_valid,
  output fetch_entry_t       o_fetch
);

  fetch_entry_t          r_mem [FBUF_DEPTH];
  logic [FBUF_PTR_W-1:0] r_wr_ptr;
  logic [FBUF_PTR_W-1:0] r_rd_ptr;
  logic [FBUF_CNT_W-1:0] r_count;
  logic                  w_pop;

  assign o_full        = (r_count == FBUF_CNT_W'(FBUF_DEPTH));
  assign o_fetch_valid = (r_count != '0);
  assign o_fetch       = r_mem[r_rd_ptr];
  assign w_pop         = o_fetch_valid & i_fetch_ready;

  // storage
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_mem[r_wr_ptr] <= i_push_entry;
    end
  end

  // pointers wrap on power of two depth
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush_valid) begin
      // everything fetched before a redirect is dead
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      r_count <= r_count + FBUF_CNT_W'(i_push) - FBUF_CNT_W'(w_pop);
    end
  end

  // the pipe must retry instead of pushing into a full buffer
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) i_push |-> !o_full)
    else $error("push into full fetch buffer");

  a_count_range : assert property (
    @(posedge i_clk) disable iff (!i_reset_n) r_count <= FBUF_CNT_W'(FBUF_DEPTH))
    else $error("fetch buffer count overflow");

endmodule

`default_nettype wire

//--- hdl/fetch_pipe.sv
// f1 and f2 stage registers with per-stage clear bits
// miss and full-buffer refetch detection, buffer push at f2

`timescale 1ns/1ps
`default_nettype none

module fetch_pipe
  import frontend_pkg::*;
(
  input  wire             i_clk,
  input  wire             i_reset_n,
  // accepted request from f0
  input  wire             i_f0_issue,
  input  wire vaddr_t     i_f0_vaddr,
  input  wire             i_flush_valid,
  // icache answer for the f2 request
  input  wire ic_resp_t   i_ic_resp,
  input  wire             i_buf_full,
  output logic            o_refetch_valid,
  output vaddr_t          o_refetch_vaddr,
  output logic            o_push,
  output fetch_entry_t    o_push_entry
);

  // ==========================================================================
  // stage registers
  // ==========================================================================

  logic   r_f1_valid;
  logic   r_f1_clear;
  vaddr_t r_f1_vaddr;

  logic   r_f2_valid;
  logic   r_f2_clear;
  vaddr_t r_f2_vaddr;

  logic   w_f2_live;
  logic   w_f2_hit;
  logic   w_kill;

  // f2 block still wanted
  assign w_f2_live = r_f2_valid & ~r_f2_clear;
  // data came back
  assign w_f2_hit  = i_ic_resp.valid & ~i_ic_resp.miss;

  // push needs data and room; a flush drops it
  assign o_push = w_f2_live & w_f2_hit & ~i_buf_full & ~i_flush_valid;

  // anything live that was not pushed goes again
  assign o_refetch_valid = w_f2_live & ~i_flush_valid & ~(w_f2_hit & ~i_buf_full);
  assign o_refetch_vaddr = r_f2_vaddr;

  assign o_push_entry.pc   = r_f2_vaddr;
  assign o_push_entry.data = i_ic_resp.data;

  // younger requests in flight are stale after any redirect
  assign w_kill = i_flush_valid | o_refetch_valid;

  // control state
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_f1_valid <= 1'b0;
      r_f1_clear <= 1'b0;
      r_f2_valid <= 1'b0;
      r_f2_clear <= 1'b0;
    end else begin
      r_f1_valid <= i_f0_issue;
      r_f1_clear <= w_kill;
      // f2 stays valid even when cleared, the cache still answers
      r_f2_valid <= r_f1_valid;
      r_f2_clear <= r_f1_clear | w_kill;
    end
  end

  // addresses ride along
  always_ff @(posedge i_clk) begin
    r_f1_vaddr <= i_f0_vaddr;
    r_f2_vaddr <= r_f1_vaddr;
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // cache answers only for a request two cycles back
  a_resp_aligned : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_ic_resp.valid |-> r_f2_valid)
    else $error("icache response without an f2 request");

endmodule

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
// f0 program counter register and next fetch address priority
// icache request generation and issue strobe

`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
  import frontend_pkg::*;
(
  input  wire           i_clk,
  input  wire           i_reset_n,
  // redirect from commit or branch
  input  wire           i_flush_valid,
  input  wire vaddr_t   i_flush_target,
  // retry of the f2 block
  input  wire           i_refetch_valid,
  input  wire vaddr_t   i_refetch_vaddr,
  // icache request port
  input  wire           i_ic_ready,
  output ic_req_t       o_ic_req,
  output logic          o_f0_issue
);

  // ==========================================================================
  // f0 state
  // ==========================================================================

  logic   r_f0_valid;
  vaddr_t r_f0_vaddr;
  vaddr_t w_f0_vaddr_next;
  vaddr_t w_f0_seq_vaddr;
  logic   w_req_accept;

  // no request while the front end is being redirected
  assign o_ic_req.valid = r_f0_valid & ~i_flush_valid & ~i_refetch_valid;
  assign o_ic_req.vaddr = r_f0_vaddr;

  assign w_req_accept = o_ic_req.valid & i_ic_ready;
  assign o_f0_issue   = w_req_accept;

  // next block: align down then step one block
  assign w_f0_seq_vaddr = {r_f0_vaddr[XLEN_W-1:FETCH_OFFS_W], {FETCH_OFFS_W{1'b0}}} +
                          vaddr_t'(FETCH_BYTES);

  // ==========================================================================
  // next address priority
  // ==========================================================================

  always_comb begin
    if (i_flush_valid) begin
      w_f0_vaddr_next = i_flush_target;
    end else if (i_refetch_valid) begin
      // miss or full buffer, go back to f2
      w_f0_vaddr_next = i_refetch_vaddr;
    end else if (!w_req_accept) begin
      // also covers the idle cycle right after reset
      w_f0_vaddr_next = r_f0_vaddr;
    end else begin
      w_f0_vaddr_next = w_f0_seq_vaddr;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_f0_valid <= 1'b0;
      r_f0_vaddr <= PC_INIT_VAL;
    end else begin
      // requests start one cycle out of reset
      r_f0_valid <= 1'b1;
      r_f0_vaddr <= w_f0_vaddr_next;
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  // a stalled request keeps its address until it is accepted or withdrawn
  property p_req_hold;
    @(posedge i_clk) disable iff (!i_reset_n)
      (o_ic_req.valid && !i_ic_ready) |=> (!o_ic_req.valid || $stable(o_ic_req.vaddr));
  endproperty

  a_req_hold : assert property (p_req_hold)
    else $error("f0 request address changed while stalled");

endmodule

`default_nettype wire

//--- hdl/trap_target.sv
// redirect target selection for commit flushes and branch mispredicts
// interrupt, exception, return and flush vectors from csr inputs

`timescale 1ns/1ps
`default_nettype none

module trap_target
  import frontend_pkg::*;
(
  input  wire commit_t  i_commit,
  input  wire csr_vec_t i_csr,
  input  wire br_upd_t  i_br_upd,
  output logic          o_flush_valid,
  output vaddr_t        o_flush_target
);

  logic        w_commit_flush;
  logic        w_br_flush;
  logic [4:0]  w_code;
  vaddr_t      w_int_target;
  vaddr_t      w_commit_target;

  assign w_commit_flush = i_commit.flush;
  // mispredict only counts on a resolved branch
  assign w_br_flush     = i_br_upd.valid & i_br_upd.mispredict;
  assign o_flush_valid  = w_commit_flush | w_br_flush;

  // raw cause bits, low nibble indexes medeleg
  assign w_code = i_commit.except_type;

  // mtvec with mode bit dropped, plus 4 * cause
  assign w_int_target = {i_csr.mtvec[XLEN_W-1:1], 1'b0} +
                        vaddr_t'({i_commit.int_cause, 2'b00});

  always_comb begin
    if (i_commit.is_int) begin
      w_commit_target = w_int_target;
    end else begin
      case (i_commit.except_type)
        SILENT_FLUSH  : w_commit_target = i_commit.epc + vaddr_t'(4);
        ANOTHER_FLUSH : w_commit_target = i_commit.epc;
        MRET          : w_commit_target = i_csr.mepc;
        SRET          : w_commit_target = i_csr.sepc;
        // each exception checks its own delegation bit
        INST_ADDR_MISALIGN, INST_ACC_FAULT, ILLEGAL_INST, BREAKPOINT,
        ECALL_U, ECALL_S, ECALL_M, INST_PAGE_FAULT : begin
          w_commit_target = i_csr.medeleg[w_code[3:0]] ? i_csr.stvec : i_csr.mtvec;
        end
        default       : w_commit_target = i_csr.mtvec;
      endcase
    end
  end

  // commit beats a same-cycle mispredict
  assign o_flush_target = w_commit_flush ? w_commit_target : i_br_upd.target;

  // commit kinds this front end knows how to vector
  always_comb begin
    if (i_commit.flush && !i_commit.is_int) begin
      assert (i_commit.except_type inside {INST_ADDR_MISALIGN, INST_ACC_FAULT,
                                           ILLEGAL_INST, BREAKPOINT, ECALL_U,
                                           ECALL_S, ECALL_M, INST_PAGE_FAULT,
                                           SILENT_FLUSH, ANOTHER_FLUSH, MRET, SRET})
        else $error("unsupported commit flush kind %0d", w_code);
    end
  end

endmodule

`default_nettype wire

//--- hdl/frontend_pkg.sv
// shared widths and constants of the fetch front end
// commit and interrupt cause encodings
// packed structs for commit, csr, branch, cache and buffer traffic

`default_nettype none

package frontend_pkg;

  // ==========================================================================
  // widths and constants
  // ==========================================================================

  // csr and address width
  localparam int XLEN_W = 32;

  typedef logic [XLEN_W-1:0] vaddr_t;

  // fetch block size in bytes
  localparam int FETCH_BYTES = 8;
  // byte offset bits inside a fetch block
  localparam int FETCH_OFFS_W = $clog2(FETCH_BYTES);

  typedef logic [FETCH_BYTES*8-1:0] fetch_data_t;

  // reset vector
  localparam vaddr_t PC_INIT_VAL = 32'h8000_0000;

  // fetch buffer geometry
  localparam int FBUF_DEPTH = 4;
  localparam int FBUF_PTR_W = $clog2(FBUF_DEPTH);
  // count needs one more bit to hold the full value
  localparam int FBUF_CNT_W = FBUF_PTR_W + 1;

  // ==========================================================================
  // cause codes
  // ==========================================================================

  // exception codes match their medeleg bit index
  typedef enum logic [4:0] {
    INST_ADDR_MISALIGN = 5'd0,
    INST_ACC_FAULT     = 5'd1,
    ILLEGAL_INST       = 5'd2,
    BREAKPOINT         = 5'd3,
    ECALL_U            = 5'd8,
    ECALL_S            = 5'd9,
    ECALL_M            = 5'd11,
    INST_PAGE_FAULT    = 5'd12,
    SILENT_FLUSH       = 5'd16,
    ANOTHER_FLUSH      = 5'd17,
    MRET               = 5'd18,
    SRET               = 5'd19
  } except_t;

  typedef enum logic [3:0] {
    SUPER_SOFT_INT       = 4'd1,
    MACHINE_SOFT_INT     = 4'd3,
    SUPER_TIMER_INT      = 4'd5,
    MACHINE_TIMER_INT    = 4'd7,
    SUPER_EXTERNAL_INT   = 4'd9,
    MACHINE_EXTERNAL_INT = 4'd11
  } int_cause_t;

  // ==========================================================================
  // packed structs
  // ==========================================================================

  // commit side redirect request
  typedef struct packed {
    logic       flush;
    logic       is_int;
    except_t    except_type;
    int_cause_t int_cause;
    vaddr_t     epc;
  } commit_t;

  // trap vectors and return addresses
  typedef struct packed {
    vaddr_t      mtvec;
    vaddr_t      stvec;
    vaddr_t      mepc;
    vaddr_t      sepc;
    logic [15:0] medeleg;
  } csr_vec_t;

  // resolved branch
  typedef struct packed {
    logic   valid;
    logic   mispredict;
    vaddr_t target;
  } br_upd_t;

  // icache request at f0
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  // icache response at f2, miss carries no data
  typedef struct packed {
    logic        valid;
    logic        miss;
    fetch_data_t data;
  } ic_resp_t;

  // one buffered fetch block
  typedef struct packed {
    vaddr_t      pc;
    fetch_data_t data;
  } fetch_entry_t;

endpackage

`default_nettype wire
